// ==== src.f ====
common/record_pkg.sv
common/buffer_pkg.sv
src/record_fifo.sv
merge_core/merge_control.sv
merge_core/merge_core.sv
src/output_stage.sv
src/record_merger.sv
sim/record_merger_chk.sv
sim/record_merger_tb.sv

// ==== Makefile ====
TOP = record_merger_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -qx "Finished with errors" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -qx "Finished with no errors" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== sim/record_merger_tb.sv ====
module record_merger_tb
   import record_pkg::*;
();

   logic    i_clk;
   logic    i_reset;
   record_t i_in_a;
   record_t i_in_b;
   logic    i_in_a_empty;
   logic    i_in_b_empty;
   logic    i_out_ready;
   logic    o_in_a_read;
   logic    o_in_b_read;
   logic    o_out_write;
   record_t o_out_data;

   // upstream model FIFOs, runs being built and the expected stream.
   record_t          src_a[$];
   record_t          src_b[$];
   record_t          run_a[$];
   record_t          run_b[$];
   record_t          exp_q[$];
   logic [KEY_W-1:0] key_buf[$];

   integer seed;
   int     value_errors = 0;
   int     count_errors = 0;
   int     cycle_count  = 0;
   int     total_queued = 0;
   logic   gaps_on      = 1'b0;
   logic   prev_ready   = 1'b0;
   logic   rd_a;
   logic   rd_b;

   record_merger i_dut (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_in_a       (i_in_a),
      .i_in_b       (i_in_b),
      .i_in_a_empty (i_in_a_empty),
      .i_in_b_empty (i_in_b_empty),
      .i_out_ready  (i_out_ready),
      .o_in_a_read  (o_in_a_read),
      .o_in_b_read  (o_in_b_read),
      .o_out_write  (o_out_write),
      .o_out_data   (o_out_data)
   );

   bind record_merger record_merger_chk u_chk (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_in_a_empty (i_in_a_empty),
      .i_in_b_empty (i_in_b_empty),
      .i_in_a_read  (o_in_a_read),
      .i_in_b_read  (o_in_b_read),
      .i_out_ready  (i_out_ready),
      .i_out_write  (o_out_write),
      .i_core_write (core_write),
      .i_stall      (stall)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   task automatic check_record(input record_t got, input record_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("ERR %0t: got key %h payload %h, expected key %h payload %h",
                  $time, got.key, got.payload, exp.key, exp.payload);
      end
   endtask

   task automatic check_strobe(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         value_errors++;
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic drive_upstream();
      logic gap_a;
      logic gap_b;
      gap_a = gaps_on && (($random(seed) & 3) == 0);
      gap_b = gaps_on && (($random(seed) & 3) == 0);
      i_in_a       = (src_a.size() != 0) ? src_a[0] : '0;
      i_in_b       = (src_b.size() != 0) ? src_b[0] : '0;
      i_in_a_empty = (src_a.size() == 0) || gap_a;
      i_in_b_empty = (src_b.size() == 0) || gap_b;
   endtask

   // upstream FIFOs and downstream sink, once per cycle.
   initial begin
      forever begin
         @(negedge i_clk);
         rd_a = o_in_a_read;
         rd_b = o_in_b_read;
         if (prev_ready !== 1'b1) begin
            check_strobe(o_out_write, 1'b0, "write strobe after a cycle with ready low");
         end
         if (o_out_write === 1'b1) begin
            if (exp_q.size() == 0) begin
               count_errors++;
               $display("extra record at time %0t with key %h", $time, o_out_data.key);
            end else begin
               check_record(o_out_data, exp_q.pop_front());
            end
         end
         prev_ready = i_out_ready;
         @(posedge i_clk);
         #1;
         if (rd_a === 1'b1 && src_a.size() != 0) begin
            src_a.delete(0);
         end
         if (rd_b === 1'b1 && src_b.size() != 0) begin
            src_b.delete(0);
         end
         drive_upstream();
      end
   end

   // sorted random keys, never the terminator key.
   task automatic random_keys(input int n);
      logic [KEY_W-1:0] k;
      int               j;
      key_buf.delete();
      for (int i = 0; i < n; i++) begin
         k = KEY_W'($random(seed)) & 32'h0000_03ff;
         k = k + 1'b1;
         j = 0;
         while (j < key_buf.size() && key_buf[j] <= k) begin
            j++;
         end
         key_buf.insert(j, k);
      end
   endtask

   task automatic build_run(input logic side_b, input logic [PAYLOAD_W-1:0] pay_base);
      record_t rec;
      foreach (key_buf[i]) begin
         rec.key     = key_buf[i];
         rec.payload = pay_base + PAYLOAD_W'(i);
         if (side_b) run_b.push_back(rec);
         else run_a.push_back(rec);
      end
      rec.key     = TERM_KEY;
      rec.payload = pay_base | 32'h0000_ffff;
      if (side_b) run_b.push_back(rec);
      else run_a.push_back(rec);
      key_buf.delete();
   endtask

   // ascending merge, a wins ties, one terminator per run pair.
   task automatic merge_reference();
      int   ia;
      int   ib;
      logic done;
      ia   = 0;
      ib   = 0;
      done = 1'b0;
      while (!done) begin
         if (run_a[ia].key == TERM_KEY && run_b[ib].key == TERM_KEY) begin
            exp_q.push_back(run_a[ia]);
            done = 1'b1;
         end else if (run_a[ia].key == TERM_KEY) begin
            exp_q.push_back(run_b[ib]);
            ib++;
         end else if (run_b[ib].key == TERM_KEY || run_a[ia].key <= run_b[ib].key) begin
            exp_q.push_back(run_a[ia]);
            ia++;
         end else begin
            exp_q.push_back(run_b[ib]);
            ib++;
         end
      end
   endtask

   task automatic commit_pair();
      merge_reference();
      foreach (run_a[i]) src_a.push_back(run_a[i]);
      foreach (run_b[i]) src_b.push_back(run_b[i]);
      total_queued += run_a.size() + run_b.size();
      run_a.delete();
      run_b.delete();
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         @(posedge i_clk);
      end
      repeat (8) @(posedge i_clk);
   endtask

   task automatic test_interleave();
      for (int i = 0; i < 4; i++) key_buf.push_back(KEY_W'(4 * i + 2));
      build_run(1'b0, 32'ha100_0000);
      for (int i = 0; i < 3; i++) key_buf.push_back(KEY_W'(4 * i + 4));
      build_run(1'b1, 32'hb100_0000);
      commit_pair();
      wait_drain();
   endtask

   task automatic test_equal_keys();
      key_buf.push_back(32'd5);
      key_buf.push_back(32'd5);
      key_buf.push_back(32'd9);
      build_run(1'b0, 32'ha200_0000);
      key_buf.push_back(32'd5);
      key_buf.push_back(32'd9);
      key_buf.push_back(32'd9);
      build_run(1'b1, 32'hb200_0000);
      commit_pair();
      wait_drain();
   endtask

   task automatic test_uneven();
      random_keys(24);
      build_run(1'b0, 32'ha300_0000);
      random_keys(3);
      build_run(1'b1, 32'hb300_0000);
      commit_pair();
      wait_drain();
   endtask

   task automatic test_back_pressure();
      @(posedge i_clk);
      #1;
      i_out_ready = 1'b0;
      random_keys(30);
      build_run(1'b0, 32'ha400_0000);
      random_keys(30);
      build_run(1'b1, 32'hb400_0000);
      commit_pair();
      repeat (100) @(posedge i_clk);
      // both input buffers must be full by now.
      @(negedge i_clk);
      check_strobe(o_in_a_read, 1'b0, "read strobe A under full back-pressure");
      check_strobe(o_in_b_read, 1'b0, "read strobe B under full back-pressure");
      @(posedge i_clk);
      #1;
      i_out_ready = 1'b1;
      wait_drain();
   endtask

   task automatic test_idle_upstream();
      gaps_on = 1'b1;
      random_keys(12);
      build_run(1'b0, 32'ha500_0000);
      random_keys(12);
      build_run(1'b1, 32'hb500_0000);
      commit_pair();
      wait_drain();
      gaps_on = 1'b0;
   endtask

   task automatic test_consecutive();
      gaps_on = 1'b1;
      for (int r = 0; r < 4; r++) begin
         random_keys(($random(seed) & 7) + 1);
         build_run(1'b0, 32'ha600_0000 + PAYLOAD_W'(r << 8));
         random_keys(($random(seed) & 7) + 1);
         build_run(1'b1, 32'hb600_0000 + PAYLOAD_W'(r << 8));
         commit_pair();
      end
      wait_drain();
      gaps_on = 1'b0;
   endtask

   task automatic end_run(input logic timed_out);
      int missing;
      missing = exp_q.size();
      if (missing != 0) begin
         $display("%0d expected records never arrived", missing);
      end
      $display("errors: %0d wrong values, %0d extra records, %0d missing, timeout %0d",
               value_errors, count_errors, missing, timed_out);
      if (value_errors == 0 && count_errors == 0 && missing == 0 && !timed_out) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   endtask

   // limit grows with every queued record.
   initial begin
      while (cycle_count < 40 * total_queued + 200) begin
         @(posedge i_clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the DUT stopped producing records", cycle_count);
      end_run(1'b1);
   end

   initial begin
      seed         = 16;
      i_reset      = 1'b1;
      i_in_a       = '0;
      i_in_b       = '0;
      i_in_a_empty = 1'b1;
      i_in_b_empty = 1'b1;
      i_out_ready  = 1'b0;
      repeat (4) @(posedge i_clk);
      #1;
      i_reset     = 1'b0;
      i_out_ready = 1'b1;
      test_interleave();
      test_equal_keys();
      test_uneven();
      test_back_pressure();
      test_idle_upstream();
      test_consecutive();
      end_run(1'b0);
   end

endmodule

// ==== sim/record_merger_chk.sv ====
module record_merger_chk (
   input logic i_clk,
   input logic i_reset,
   input logic i_in_a_empty,
   input logic i_in_b_empty,
   input logic i_in_a_read,
   input logic i_in_b_read,
   input logic i_out_ready,
   input logic i_out_write,
   input logic i_core_write,
   input logic i_stall
);

   // never read from an empty upstream FIFO.
   a_read_empty: assert property (@(posedge i_clk) disable iff (i_reset)
      !(i_in_a_read && i_in_a_empty))
      else $error("read strobe A high while upstream A is empty");

   b_read_empty: assert property (@(posedge i_clk) disable iff (i_reset)
      !(i_in_b_read && i_in_b_empty))
      else $error("read strobe B high while upstream B is empty");

   // downstream ready is registered, so low ready blocks the next write.
   write_after_ready: assert property (@(posedge i_clk) disable iff (i_reset)
      !$past(i_out_ready) |-> !i_out_write)
      else $error("output write after a cycle with ready low");

   // a stalled core emits nothing.
   write_after_stall: assert property (@(posedge i_clk) disable iff (i_reset)
      $past(i_stall) |-> !i_core_write)
      else $error("core write pulse after a stalled cycle");

endmodule

// ==== src/record_merger.sv ====
module record_merger
   import record_pkg::*;
(
   input  logic    i_clk,
   input  logic    i_reset,
   input  record_t i_in_a,
   input  record_t i_in_b,
   input  logic    i_in_a_empty,
   input  logic    i_in_b_empty,
   input  logic    i_out_ready,
   output logic    o_in_a_read,
   output logic    o_in_b_read,
   output logic    o_out_write,
   output record_t o_out_data
);

   record_t head_a;
   record_t head_b;
   logic    empty_a;
   logic    empty_b;
   logic    full_a;
   logic    full_b;
   logic    deq_a;
   logic    deq_b;
   logic    core_write;
   record_t core_record;
   logic    stall;

   // pull from upstream whenever there is room.
   assign o_in_a_read = ~i_in_a_empty & ~full_a;
   assign o_in_b_read = ~i_in_b_empty & ~full_b;

   record_fifo in_buf_a (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_enq   (o_in_a_read),
      .i_deq   (deq_a),
      .i_data  (i_in_a),
      .o_data  (head_a),
      .o_empty (empty_a),
      .o_full  (full_a),
      .o_count ()
   );

   record_fifo in_buf_b (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_enq   (o_in_b_read),
      .i_deq   (deq_b),
      .i_data  (i_in_b),
      .o_data  (head_b),
      .o_empty (empty_b),
      .o_full  (full_b),
      .o_count ()
   );

   merge_core u_core (
      .i_clk     (i_clk),
      .i_reset   (i_reset),
      .i_head_a  (head_a),
      .i_head_b  (head_b),
      .i_empty_a (empty_a),
      .i_empty_b (empty_b),
      .i_stall   (stall),
      .o_deq_a   (deq_a),
      .o_deq_b   (deq_b),
      .o_write   (core_write),
      .o_record  (core_record)
   );

   output_stage u_out (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_write     (core_write),
      .i_record    (core_record),
      .i_out_ready (i_out_ready),
      .o_stall     (stall),
      .o_out_write (o_out_write),
      .o_out_data  (o_out_data)
   );

endmodule

// ==== src/output_stage.sv ====
module output_stage
   import record_pkg::*, buffer_pkg::*;
(
   input  logic    i_clk,
   input  logic    i_reset,
   input  logic    i_write,
   input  record_t i_record,
   input  logic    i_out_ready,
   output logic    o_stall,
   output logic    o_out_write,
   output record_t o_out_data
);

   logic             ready_q;
   logic             out_empty;
   logic [CNT_W-1:0] out_count;

   // downstream ready is sampled once before use.
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= i_out_ready;
      end
   end

   record_fifo out_buf (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_enq   (i_write),
      .i_deq   (o_out_write),
      .i_data  (i_record),
      .o_data  (o_out_data),
      .o_empty (out_empty),
      .o_full  (),
      .o_count (out_count)
   );

   // the head leaves in the same cycle it is written downstream.
   assign o_out_write = ready_q & ~out_empty;

   assign o_stall = (out_count >= OUT_STALL_LEVEL);

endmodule

// ==== merge_core/merge_core.sv ====
module merge_core
   import record_pkg::*;
(
   input  logic    i_clk,
   input  logic    i_reset,
   input  record_t i_head_a,
   input  record_t i_head_b,
   input  logic    i_empty_a,
   input  logic    i_empty_b,
   input  logic    i_stall,
   output logic    o_deq_a,
   output logic    o_deq_b,
   output logic    o_write,
   output record_t o_record
);

   logic    take_a;
   logic    take_b;
   logic    emit;
   logic    emit_sel_a;
   record_t sel_record;

   merge_control u_control (
      .i_head_a     (i_head_a),
      .i_head_b     (i_head_b),
      .i_empty_a    (i_empty_a),
      .i_empty_b    (i_empty_b),
      .i_stall      (i_stall),
      .o_take_a     (take_a),
      .o_take_b     (take_b),
      .o_emit       (emit),
      .o_emit_sel_a (emit_sel_a)
   );

   // taken heads pop at the same edge that captures them.
   assign o_deq_a = take_a;
   assign o_deq_b = take_b;

   assign sel_record = emit_sel_a ? i_head_a : i_head_b;

   always_ff @(posedge i_clk) begin
      if (emit) begin
         o_record <= sel_record;
      end
   end

   // one write per emitted record.
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_write <= 1'b0;
      end else begin
         o_write <= emit;
      end
   end

endmodule

// ==== merge_core/merge_control.sv ====
module merge_control
   import record_pkg::*;
(
   input  record_t i_head_a,
   input  record_t i_head_b,
   input  logic    i_empty_a,
   input  logic    i_empty_b,
   input  logic    i_stall,
   output logic    o_take_a,
   output logic    o_take_b,
   output logic    o_emit,
   output logic    o_emit_sel_a
);

   logic [KEY_W-1:0] key_a;
   logic [KEY_W-1:0] key_b;
   logic             a_term;
   logic             b_term;
   logic             a_le_b;
   logic             go;

   assign key_a  = i_head_a.key;
   assign key_b  = i_head_b.key;
   assign a_term = (key_a == TERM_KEY);
   assign b_term = (key_b == TERM_KEY);
   assign a_le_b = (key_a <= key_b);

   // a decision needs both heads, even a terminator, to be present.
   assign go = ~i_empty_a & ~i_empty_b & ~i_stall;

   always_comb begin
      o_take_a     = 1'b0;
      o_take_b     = 1'b0;
      o_emit_sel_a = 1'b1;
      if (a_term && b_term) begin
         // end of both runs, one terminator goes out.
         o_take_a     = go;
         o_take_b     = go;
         o_emit_sel_a = 1'b1;
      end else if (a_term) begin
         o_take_b     = go;
         o_emit_sel_a = 1'b0;
      end else if (b_term) begin
         o_take_a     = go;
         o_emit_sel_a = 1'b1;
      end else begin
         // ties go to a.
         o_take_a     = go & a_le_b;
         o_take_b     = go & ~a_le_b;
         o_emit_sel_a = a_le_b;
      end
   end

   assign o_emit = go;

endmodule

// ==== src/record_fifo.sv ====
module record_fifo
   import record_pkg::*, buffer_pkg::*;
(
   input  logic             i_clk,
   input  logic             i_reset,
   input  logic             i_enq,
   input  logic             i_deq,
   input  record_t          i_data,
   output record_t          o_data,
   output logic             o_empty,
   output logic             o_full,
   output logic [CNT_W-1:0] o_count
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   logic [REC_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_enq;
   logic             do_deq;

   // requests that would overrun or underrun are dropped.
   assign do_enq = i_enq & ~o_full;
   assign do_deq = i_deq & ~o_empty;

   always_ff @(posedge i_clk) begin
      if (do_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_enq) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_deq) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_enq, do_deq})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head is visible without a read.
   assign o_data  = record_t'(mem[rd_ptr]);
   assign o_empty = (count == '0);
   assign o_full  = (count == CNT_W'(FIFO_DEPTH));
   assign o_count = count;

endmodule

// ==== common/buffer_pkg.sv ====
package buffer_pkg;

   // entries per record buffer.
   localparam int FIFO_DEPTH = 16;

   // count needs one bit more than the pointers to reach FIFO_DEPTH.
   localparam int CNT_W = 5;

   // stall the core here; one record may sit in the register stage
   // and one more may be on its way into the output buffer.
   localparam logic [CNT_W-1:0] OUT_STALL_LEVEL = 5'd13;

endpackage

// ==== common/record_pkg.sv ====
package record_pkg;

   // record field widths.
   localparam int KEY_W     = 32;
   localparam int PAYLOAD_W = 32;
   localparam int REC_W     = PAYLOAD_W + KEY_W;

   // a zero key closes a run.
   localparam logic [KEY_W-1:0] TERM_KEY = '0;

   // payload in the upper half, sort key in the lower half.
   typedef struct packed {
      logic [PAYLOAD_W-1:0] payload;
      logic [KEY_W-1:0]     key;
   } record_t;

endpackage
